/* hw/rv_isa_pkg.sv */
// RV64I subset encodings: opcode, funct3, funct7, ALU op and branch kind enums, field widths
`default_nettype none

package rv_isa_pkg;

	// ******************************
	// instruction field widths
	// ******************************
	localparam int REG_IDX_W = 5;
	localparam int INST_W    = 32;
	// architectural register count
	localparam int NUM_REGS  = 1 << REG_IDX_W;

	// major opcodes, supported subset only
	typedef enum logic [6:0] {
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011,
		LUI    = 7'b0110111,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111
	} opcode_e;

	// funct3 of OP and OP_IMM
	typedef enum logic [2:0] {
		F3_ADD = 3'b000,
		F3_SLL = 3'b001,
		F3_XOR = 3'b100,
		F3_OR  = 3'b110,
		F3_AND = 3'b111
	} alu_funct3_e;

	// funct3 of BRANCH
	typedef enum logic [2:0] {
		F3_BEQ = 3'b000,
		F3_BNE = 3'b001
	} br_funct3_e;

	// funct7, alt form turns add into sub
	typedef enum logic [6:0] {
		F7_BASE = 7'b0000000,
		F7_ALT  = 7'b0100000
	} funct7_e;

	// ******************************
	// internal control encodings
	// ******************************
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_PASSB
	} alu_op_e;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_JAL
	} br_kind_e;

endpackage

`default_nettype wire

/* hw/core_pkg.sv */
// core constants and packed stage payload structs
`default_nettype none

package core_pkg;

	// ******************************
	// core constants
	// ******************************
	localparam int XLEN        = 64;
	localparam int IMEM_DEPTH  = 256;
	localparam int IMEM_ADDR_W = 8;
	localparam logic [XLEN-1:0] RESET_PC = '0;

	// fetch to decode
	typedef struct packed {
		logic [XLEN-1:0]               pc;
		logic [rv_isa_pkg::INST_W-1:0] inst;
	} fetch_pkt_t;

	// decode to execute, operands already read
	typedef struct packed {
		logic [XLEN-1:0]                  pc;
		logic [XLEN-1:0]                  op_a;
		logic [XLEN-1:0]                  op_b;
		rv_isa_pkg::alu_op_e              alu_op;
		rv_isa_pkg::br_kind_e             br_kind;
		// branch or jump offset, pc relative
		logic [XLEN-1:0]                  br_off;
		logic [rv_isa_pkg::REG_IDX_W-1:0] rd;
		logic                             wen;
	} issue_pkt_t;

	// execute to writeback and retire port
	typedef struct packed {
		logic [XLEN-1:0]                  pc;
		logic [rv_isa_pkg::REG_IDX_W-1:0] rd;
		logic                             wen;
		logic [XLEN-1:0]                  data;
	} retire_pkt_t;

	// execute back to fetch and decode
	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] target;
	} redirect_t;

endpackage

`default_nettype wire

/* hw/regfile.sv */
// general register file: 32 x 64, two combinational read ports, one write port, x0 tied to zero
`default_nettype none

module regfile (
	input  logic                             clk,
	input  logic [rv_isa_pkg::REG_IDX_W-1:0] raddr_a,
	input  logic [rv_isa_pkg::REG_IDX_W-1:0] raddr_b,
	output logic [core_pkg::XLEN-1:0]        rdata_a,
	output logic [core_pkg::XLEN-1:0]        rdata_b,
	input  logic                             wen,
	input  logic [rv_isa_pkg::REG_IDX_W-1:0] waddr,
	input  logic [core_pkg::XLEN-1:0]        wdata
);
	import core_pkg::*;
	import rv_isa_pkg::*;

	// storage, entry 0 never written
	logic [XLEN-1:0] regs [NUM_REGS];

	// write port
	always_ff @(posedge clk) begin
		if (wen && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	// read ports, x0 masked to zero
	assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
	assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

/* hw/fetch_unit.sv */
// fetch unit: instruction memory, pc, redirect handling, fetch to decode register
`default_nettype none

module fetch_unit (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               start,
	input  logic                               imem_we,
	input  logic [core_pkg::IMEM_ADDR_W-1:0]   imem_waddr,
	input  logic [rv_isa_pkg::INST_W-1:0]      imem_wdata,
	input  core_pkg::redirect_t                redirect,
	output logic                               fd_valid,
	input  logic                               fd_ready,
	output core_pkg::fetch_pkt_t               fd_pkt
);
	import core_pkg::*;
	import rv_isa_pkg::*;

	logic [INST_W-1:0]      imem [IMEM_DEPTH];
	logic                   running;
	logic [XLEN-1:0]        pc;
	logic [IMEM_ADDR_W-1:0] raddr;
	logic                   advance;

	// word index from byte pc, wraps over the memory
	assign raddr = pc[IMEM_ADDR_W+1:2];

	// output register free or draining this cycle
	assign advance = running && (!fd_valid || fd_ready);

	// ******************************
	// instruction memory
	// ******************************
	// load port, used only while idle
	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_waddr] <= imem_wdata;
		end
	end

	// synchronous read straight into the output payload
	always_ff @(posedge clk) begin
		if (advance && !redirect.valid) begin
			fd_pkt.pc   <= pc;
			fd_pkt.inst <= imem[raddr];
		end
	end

	// ******************************
	// pc and output valid
	// ******************************
	always_ff @(posedge clk) begin
		if (rst) begin
			running  <= 1'b0;
			pc       <= RESET_PC;
			fd_valid <= 1'b0;
		end else begin
			if (start) begin
				running <= 1'b1;
			end
			// redirect wins, current output is wrong path
			if (redirect.valid) begin
				pc       <= redirect.target;
				fd_valid <= 1'b0;
			end else if (advance) begin
				pc       <= pc + XLEN'(4);
				fd_valid <= 1'b1;
			end
		end
	end

	// program load must finish before the core runs
	a_no_load_running: assert property (@(posedge clk) disable iff (rst) running |-> !imem_we)
		else $error("imem written while fetch is running");

endmodule

`default_nettype wire

/* hw/decode_unit.sv */
// decode unit: field and immediate extraction, ALU op select, busy scoreboard, issue stall
`default_nettype none

module decode_unit (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             fd_valid,
	output logic                             fd_ready,
	input  core_pkg::fetch_pkt_t             fd_pkt,
	output logic [rv_isa_pkg::REG_IDX_W-1:0] rs_a,
	output logic [rv_isa_pkg::REG_IDX_W-1:0] rs_b,
	input  logic [core_pkg::XLEN-1:0]        rdata_a,
	input  logic [core_pkg::XLEN-1:0]        rdata_b,
	input  logic                             busy_clear_valid,
	input  logic [rv_isa_pkg::REG_IDX_W-1:0] busy_clear_idx,
	input  core_pkg::redirect_t              redirect,
	output logic                             de_valid,
	input  logic                             de_ready,
	output core_pkg::issue_pkt_t             de_pkt
);
	import core_pkg::*;
	import rv_isa_pkg::*;

	// held instruction
	logic                 hold_valid;
	fetch_pkt_t           hold;
	// decoded fields
	logic [INST_W-1:0]    inst;
	opcode_e              opcode;
	alu_funct3_e          f3_alu;
	br_funct3_e           f3_br;
	funct7_e              funct7;
	logic [REG_IDX_W-1:0] rd;
	logic [XLEN-1:0]      imm_i;
	logic [XLEN-1:0]      imm_u;
	logic [XLEN-1:0]      imm_b;
	logic [XLEN-1:0]      imm_j;
	logic                 use_rs1;
	logic                 use_rs2;
	logic                 writes_rd;
	// scoreboard
	logic [NUM_REGS-1:0]  busy_q;
	logic [NUM_REGS-1:0]  set_mask;
	logic [NUM_REGS-1:0]  clr_mask;
	logic                 stall;
	logic                 issue;

	// ******************************
	// field extraction
	// ******************************
	assign inst   = hold.inst;
	assign opcode = opcode_e'(inst[6:0]);
	assign f3_alu = alu_funct3_e'(inst[14:12]);
	assign f3_br  = br_funct3_e'(inst[14:12]);
	assign funct7 = funct7_e'(inst[31:25]);
	assign rd     = inst[11:7];
	assign rs_a   = inst[19:15];
	assign rs_b   = inst[24:20];

	// sign extended immediates
	assign imm_i = {{(XLEN-12){inst[31]}}, inst[31:20]};
	assign imm_u = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};
	assign imm_b = {{(XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_j = {{(XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	// operand and control select per opcode
	always_comb begin
		de_pkt.pc      = hold.pc;
		de_pkt.op_a    = rdata_a;
		de_pkt.op_b    = rdata_b;
		de_pkt.alu_op  = ALU_ADD;
		de_pkt.br_kind = BR_NONE;
		de_pkt.br_off  = imm_b;
		de_pkt.rd      = rd;
		use_rs1        = 1'b0;
		use_rs2        = 1'b0;
		writes_rd      = 1'b0;
		case (opcode)
			OP_IMM: begin
				use_rs1     = 1'b1;
				writes_rd   = 1'b1;
				// slli shamt sits in the low six bits of imm_i
				de_pkt.op_b = imm_i;
				case (f3_alu)
					F3_SLL:  de_pkt.alu_op = ALU_SLL;
					F3_XOR:  de_pkt.alu_op = ALU_XOR;
					F3_OR:   de_pkt.alu_op = ALU_OR;
					F3_AND:  de_pkt.alu_op = ALU_AND;
					default: de_pkt.alu_op = ALU_ADD;
				endcase
			end
			OP: begin
				use_rs1   = 1'b1;
				use_rs2   = 1'b1;
				writes_rd = 1'b1;
				case (f3_alu)
					F3_ADD: begin
						case (funct7)
							F7_BASE: de_pkt.alu_op = ALU_ADD;
							F7_ALT:  de_pkt.alu_op = ALU_SUB;
							default: de_pkt.alu_op = ALU_ADD;
						endcase
					end
					F3_SLL:  de_pkt.alu_op = ALU_SLL;
					F3_XOR:  de_pkt.alu_op = ALU_XOR;
					F3_OR:   de_pkt.alu_op = ALU_OR;
					default: de_pkt.alu_op = ALU_AND;
				endcase
			end
			LUI: begin
				writes_rd     = 1'b1;
				de_pkt.op_a   = '0;
				de_pkt.op_b   = imm_u;
				de_pkt.alu_op = ALU_PASSB;
			end
			BRANCH: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				case (f3_br)
					F3_BEQ:  de_pkt.br_kind = BR_EQ;
					F3_BNE:  de_pkt.br_kind = BR_NE;
					default: de_pkt.br_kind = BR_NONE;
				endcase
			end
			JAL: begin
				// link value pc + 4 comes out of the ALU
				writes_rd      = 1'b1;
				de_pkt.op_a    = hold.pc;
				de_pkt.op_b    = XLEN'(4);
				de_pkt.br_kind = BR_JAL;
				de_pkt.br_off  = imm_j;
			end
			default: ;
		endcase
		// x0 writes dropped here, never marked busy
		de_pkt.wen = writes_rd && (rd != '0);
	end

	// ******************************
	// stall, issue and handshake
	// ******************************
	// rd checked too, two pending writes to one reg would clear its bit early
	assign stall = (use_rs1 && busy_q[rs_a]) || (use_rs2 && busy_q[rs_b])
		|| (de_pkt.wen && busy_q[rd]);
	// nothing issues while a redirect squashes the held instruction
	assign de_valid = hold_valid && !stall && !redirect.valid;
	assign issue    = de_valid && de_ready;
	assign fd_ready = !hold_valid || issue;

	always_ff @(posedge clk) begin
		if (rst) begin
			hold_valid <= 1'b0;
		end else if (redirect.valid) begin
			hold_valid <= 1'b0;
		end else if (fd_ready) begin
			hold_valid <= fd_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (fd_valid && fd_ready) begin
			hold <= fd_pkt;
		end
	end

	// busy vector, set at issue beats clear
	always_comb begin
		set_mask = '0;
		clr_mask = '0;
		if (issue && de_pkt.wen) begin
			set_mask[de_pkt.rd] = 1'b1;
		end
		if (busy_clear_valid) begin
			clr_mask[busy_clear_idx] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= '0;
		end else begin
			busy_q <= (busy_q & ~clr_mask) | set_mask;
		end
	end

	a_x0_never_busy: assert property (@(posedge clk) disable iff (rst) !busy_q[0])
		else $error("busy bit of x0 set");

	// writeback only releases registers that issue marked
	a_clear_of_busy: assert property (@(posedge clk) disable iff (rst)
		busy_clear_valid |-> busy_q[busy_clear_idx])
		else $error("busy clear for a register that is not busy");

endmodule

`default_nettype wire

/* hw/execute_unit.sv */
// execute unit: ALU, branch and jump resolution, redirect, execute to writeback register
`default_nettype none

module execute_unit (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  de_valid,
	output logic                  de_ready,
	input  core_pkg::issue_pkt_t  de_pkt,
	output core_pkg::redirect_t   redirect,
	output logic                  ew_valid,
	output core_pkg::retire_pkt_t ew_pkt
);
	import core_pkg::*;
	import rv_isa_pkg::*;

	logic            accept;
	logic [XLEN-1:0] result;
	logic            taken;
	logic            redirect_valid_q;
	logic [XLEN-1:0] redirect_target_q;

	// writeback never stalls, so neither does execute
	assign de_ready = 1'b1;
	assign accept   = de_valid && de_ready;

	// ******************************
	// ALU
	// ******************************
	always_comb begin
		case (de_pkt.alu_op)
			ALU_SUB:   result = de_pkt.op_a - de_pkt.op_b;
			ALU_AND:   result = de_pkt.op_a & de_pkt.op_b;
			ALU_OR:    result = de_pkt.op_a | de_pkt.op_b;
			ALU_XOR:   result = de_pkt.op_a ^ de_pkt.op_b;
			// rv64 shift amount is six bits
			ALU_SLL:   result = de_pkt.op_a << de_pkt.op_b[5:0];
			ALU_PASSB: result = de_pkt.op_b;
			default:   result = de_pkt.op_a + de_pkt.op_b;
		endcase
	end

	// branch condition on the raw operands
	always_comb begin
		case (de_pkt.br_kind)
			BR_EQ:   taken = (de_pkt.op_a == de_pkt.op_b);
			BR_NE:   taken = (de_pkt.op_a != de_pkt.op_b);
			BR_JAL:  taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	// ******************************
	// output registers
	// ******************************
	always_ff @(posedge clk) begin
		if (rst) begin
			ew_valid         <= 1'b0;
			redirect_valid_q <= 1'b0;
		end else begin
			ew_valid         <= accept;
			redirect_valid_q <= accept && taken;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			ew_pkt.pc         <= de_pkt.pc;
			ew_pkt.rd         <= de_pkt.rd;
			ew_pkt.wen        <= de_pkt.wen;
			ew_pkt.data       <= result;
			redirect_target_q <= de_pkt.pc + de_pkt.br_off;
		end
	end

	assign redirect.valid  = redirect_valid_q;
	assign redirect.target = redirect_target_q;

	// decode squashes its held instruction while a redirect is out
	a_redirect_after_accept: assert property (@(posedge clk) disable iff (rst)
		redirect.valid |-> !accept)
		else $error("wrong-path instruction accepted during redirect");

endmodule

`default_nettype wire

/* hw/writeback_unit.sv */
// writeback unit: register file write, busy release, retire record, retire counter
`default_nettype none

module writeback_unit (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             ew_valid,
	input  core_pkg::retire_pkt_t            ew_pkt,
	output logic                             rf_wen,
	output logic [rv_isa_pkg::REG_IDX_W-1:0] rf_waddr,
	output logic [core_pkg::XLEN-1:0]        rf_wdata,
	output logic                             busy_clear_valid,
	output logic [rv_isa_pkg::REG_IDX_W-1:0] busy_clear_idx,
	output logic                             retire_valid,
	output core_pkg::retire_pkt_t            retire_pkt,
	output logic [31:0]                      retire_count
);
	// retire register, one cycle behind execute
	always_ff @(posedge clk) begin
		if (rst) begin
			retire_valid <= 1'b0;
			retire_count <= '0;
		end else begin
			retire_valid <= ew_valid;
			if (retire_valid) begin
				retire_count <= retire_count + 32'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ew_valid) begin
			retire_pkt <= ew_pkt;
		end
	end

	// write and release land on the same edge
	assign rf_wen           = retire_valid && retire_pkt.wen;
	assign rf_waddr         = retire_pkt.rd;
	assign rf_wdata         = retire_pkt.data;
	assign busy_clear_valid = rf_wen;
	assign busy_clear_idx   = retire_pkt.rd;

endmodule

`default_nettype wire

/* hw/core_top.sv */
// core top level: fetch, decode, execute, writeback and register file
`default_nettype none

module core_top (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             start,
	input  logic                             imem_we,
	input  logic [core_pkg::IMEM_ADDR_W-1:0] imem_waddr,
	input  logic [rv_isa_pkg::INST_W-1:0]    imem_wdata,
	output logic                             retire_valid,
	output core_pkg::retire_pkt_t            retire_pkt,
	output logic [31:0]                      retire_count
);
	import core_pkg::*;
	import rv_isa_pkg::*;

	// ******************************
	// stage links
	// ******************************
	logic                 fd_valid;
	logic                 fd_ready;
	fetch_pkt_t           fd_pkt;
	logic                 de_valid;
	logic                 de_ready;
	issue_pkt_t           de_pkt;
	logic                 ew_valid;
	retire_pkt_t          ew_pkt;
	redirect_t            redirect;
	// register file side
	logic [REG_IDX_W-1:0] rs_a;
	logic [REG_IDX_W-1:0] rs_b;
	logic [XLEN-1:0]      rdata_a;
	logic [XLEN-1:0]      rdata_b;
	logic                 rf_wen;
	logic [REG_IDX_W-1:0] rf_waddr;
	logic [XLEN-1:0]      rf_wdata;
	logic                 busy_clear_valid;
	logic [REG_IDX_W-1:0] busy_clear_idx;

	fetch_unit u_fetch (
		.clk(clk), .rst(rst), .start(start),
		.imem_we(imem_we), .imem_waddr(imem_waddr), .imem_wdata(imem_wdata),
		.redirect(redirect),
		.fd_valid(fd_valid), .fd_ready(fd_ready), .fd_pkt(fd_pkt)
	);

	decode_unit u_decode (
		.clk(clk), .rst(rst),
		.fd_valid(fd_valid), .fd_ready(fd_ready), .fd_pkt(fd_pkt),
		.rs_a(rs_a), .rs_b(rs_b), .rdata_a(rdata_a), .rdata_b(rdata_b),
		.busy_clear_valid(busy_clear_valid), .busy_clear_idx(busy_clear_idx),
		.redirect(redirect),
		.de_valid(de_valid), .de_ready(de_ready), .de_pkt(de_pkt)
	);

	execute_unit u_execute (
		.clk(clk), .rst(rst),
		.de_valid(de_valid), .de_ready(de_ready), .de_pkt(de_pkt),
		.redirect(redirect), .ew_valid(ew_valid), .ew_pkt(ew_pkt)
	);

	writeback_unit u_writeback (
		.clk(clk), .rst(rst), .ew_valid(ew_valid), .ew_pkt(ew_pkt),
		.rf_wen(rf_wen), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.busy_clear_valid(busy_clear_valid), .busy_clear_idx(busy_clear_idx),
		.retire_valid(retire_valid), .retire_pkt(retire_pkt), .retire_count(retire_count)
	);

	regfile u_regfile (
		.clk(clk), .raddr_a(rs_a), .raddr_b(rs_b), .rdata_a(rdata_a), .rdata_b(rdata_b),
		.wen(rf_wen), .waddr(rf_waddr), .wdata(rf_wdata)
	);

endmodule

`default_nettype wire

/* bench/core_ref_model.svh */
// architectural reference model: runs the loaded program image and fills the expected retire arrays
`ifndef CORE_REF_MODEL_SVH
`define CORE_REF_MODEL_SVH

// runs from pc 0 until the closing self jump has retired three times
function automatic int run_ref_model();
	logic [XLEN-1:0] x [32];
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] npc;
	logic [XLEN-1:0] res;
	logic [XLEN-1:0] imm;
	logic [XLEN-1:0] a;
	logic [XLEN-1:0] b;
	logic [31:0]     ins;
	logic            wr;
	int              n;
	int              hits;
	int              r;
	for (r = 0; r < 32; r++) begin
		x[r] = '0;
	end
	pc = '0;
	n = 0;
	hits = 0;
	while (n < IMEM_DEPTH && hits < 3) begin
		ins = prog[pc[IMEM_ADDR_W+1:2]];
		a = x[ins[19:15]];
		b = x[ins[24:20]];
		npc = pc + 64'd4;
		res = '0;
		wr = 1'b0;
		case (ins[6:0])
			// register-immediate ops
			7'h13: begin
				imm = {{52{ins[31]}}, ins[31:20]};
				wr = 1'b1;
				case (ins[14:12])
					3'd1:    res = a << imm[5:0];
					3'd4:    res = a ^ imm;
					3'd6:    res = a | imm;
					3'd7:    res = a & imm;
					default: res = a + imm;
				endcase
			end
			// register-register ops, bit 30 selects sub
			7'h33: begin
				wr = 1'b1;
				case (ins[14:12])
					3'd0:    res = ins[30] ? (a - b) : (a + b);
					3'd1:    res = a << b[5:0];
					3'd4:    res = a ^ b;
					3'd6:    res = a | b;
					default: res = a & b;
				endcase
			end
			7'h37: begin
				wr = 1'b1;
				res = {{32{ins[31]}}, ins[31:12], 12'h000};
			end
			7'h63: begin
				imm = {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
				if ((ins[14:12] == 3'd0 && a == b) || (ins[14:12] == 3'd1 && a != b)) begin
					npc = pc + imm;
				end
			end
			7'h6f: begin
				imm = {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
				wr = 1'b1;
				res = pc + 64'd4;
				npc = pc + imm;
				// jump to itself marks the end of the program
				if (imm == '0) begin
					hits++;
				end
			end
			default: ;
		endcase
		exp_pc[n] = pc;
		exp_rd[n] = ins[11:7];
		exp_wen[n] = wr && (ins[11:7] != 5'd0);
		exp_data[n] = res;
		if (exp_wen[n]) begin
			x[ins[11:7]] = res;
		end
		pc = npc;
		n++;
	end
	return n;
endfunction

`endif

/* bench/core_tb.sv */
// core testbench: encoders, program builders, LFSR stimulus, loader, retire compare, final report
`default_nettype none

module core_tb;
	import core_pkg::*;

	localparam int TIMEOUT_CYCLES = 5000;

	logic                   clk;
	logic                   rst;
	logic                   start;
	logic                   imem_we;
	logic [IMEM_ADDR_W-1:0] imem_waddr;
	logic [31:0]            imem_wdata;
	logic                   retire_valid;
	retire_pkt_t            retire_pkt;
	logic [31:0]            retire_count;

	// program image, always the full memory
	logic [31:0]     prog [IMEM_DEPTH];
	int              prog_len;
	string           prog_name;
	logic [31:0]     lfsr;
	// expected retire sequence
	logic [XLEN-1:0] exp_pc [IMEM_DEPTH];
	logic [4:0]      exp_rd [IMEM_DEPTH];
	logic            exp_wen [IMEM_DEPTH];
	logic [XLEN-1:0] exp_data [IMEM_DEPTH];
	int              exp_count;
	int              seen;
	int              mismatches;
	int              timeouts;
	logic            aborted;

	core_top UUT (
		.clk(clk), .rst(rst), .start(start),
		.imem_we(imem_we), .imem_waddr(imem_waddr), .imem_wdata(imem_wdata),
		.retire_valid(retire_valid), .retire_pkt(retire_pkt), .retire_count(retire_count)
	);

	always #4 clk = ~clk;

	`include "core_ref_model.svh"

	// ******************************
	// instruction encoders
	// ******************************
	function automatic logic [31:0] imm_op(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
		logic [11:0] imm);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] reg_op(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
		logic [4:0] rs1, logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] lui_word(logic [4:0] rd, logic [19:0] imm);
		return {imm, rd, 7'b0110111};
	endfunction

	// offset in bytes, bit 0 dropped
	function automatic logic [31:0] branch_word(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
		logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] jal_word(logic [4:0] rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	// galois LFSR, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// ******************************
	// program builders
	// ******************************
	task automatic emit(input logic [31:0] word);
		prog[prog_len] = word;
		prog_len++;
	endtask

	// unused words become x0 adds tagged with their address
	task automatic clear_program();
		int a;
		prog_len = 0;
		for (a = 0; a < IMEM_DEPTH; a++) begin
			prog[a] = imm_op(3'd0, 5'd0, 5'd0, {4'h8, 8'(a)});
		end
	endtask

	// regfile has no reset, so x1..x7 get defined first
	task automatic emit_prologue();
		int i;
		for (i = 1; i < 8; i++) begin
			emit(imm_op(3'd0, 5'(i), 5'd0, 12'(i * 421)));
		end
	endtask

	task automatic alu_program();
		clear_program();
		emit_prologue();
		emit(imm_op(3'd0, 5'd1, 5'd2, 12'hff9));
		emit(imm_op(3'd7, 5'd3, 5'd4, 12'h0f0));
		emit(imm_op(3'd6, 5'd5, 5'd6, 12'h801));
		emit(imm_op(3'd4, 5'd7, 5'd1, 12'h5a5));
		emit(imm_op(3'd1, 5'd2, 5'd3, 12'd33));
		emit(reg_op(7'h00, 3'd0, 5'd4, 5'd1, 5'd2));
		emit(reg_op(7'h20, 3'd0, 5'd6, 5'd5, 5'd7));
		emit(reg_op(7'h00, 3'd7, 5'd1, 5'd4, 5'd6));
		emit(reg_op(7'h00, 3'd6, 5'd3, 5'd1, 5'd2));
		emit(reg_op(7'h00, 3'd4, 5'd5, 5'd3, 5'd4));
		emit(lui_word(5'd7, 20'h80123));
		emit(lui_word(5'd2, 20'h7fabc));
		emit(jal_word(5'd0, 21'd0));
	endtask

	// every instruction reads the one before it
	task automatic raw_chain_program();
		clear_program();
		emit_prologue();
		emit(imm_op(3'd0, 5'd1, 5'd1, 12'd1));
		emit(reg_op(7'h00, 3'd0, 5'd2, 5'd1, 5'd1));
		emit(reg_op(7'h00, 3'd0, 5'd3, 5'd2, 5'd1));
		emit(reg_op(7'h20, 3'd0, 5'd4, 5'd3, 5'd2));
		emit(reg_op(7'h00, 3'd4, 5'd5, 5'd4, 5'd3));
		emit(imm_op(3'd1, 5'd6, 5'd5, 12'd3));
		emit(reg_op(7'h00, 3'd6, 5'd7, 5'd6, 5'd5));
		emit(reg_op(7'h00, 3'd0, 5'd1, 5'd7, 5'd7));
		emit(imm_op(3'd0, 5'd1, 5'd1, 12'hfff));
		emit(imm_op(3'd0, 5'd1, 5'd1, 12'hfff));
		emit(jal_word(5'd0, 21'd0));
	endtask

	// taken and not-taken branches, jal link, squashed slots write x3, x4, x7, x1, x2
	task automatic branch_program();
		clear_program();
		emit_prologue();
		emit(branch_word(3'd0, 5'd1, 5'd1, 13'd12));
		emit(imm_op(3'd0, 5'd3, 5'd0, 12'd1));
		emit(imm_op(3'd0, 5'd3, 5'd0, 12'd2));
		emit(branch_word(3'd1, 5'd1, 5'd2, 13'd8));
		emit(imm_op(3'd0, 5'd4, 5'd0, 12'd3));
		emit(branch_word(3'd0, 5'd1, 5'd2, 13'd8));
		emit(imm_op(3'd0, 5'd5, 5'd0, 12'd4));
		emit(branch_word(3'd1, 5'd3, 5'd3, 13'd8));
		emit(imm_op(3'd0, 5'd6, 5'd0, 12'd5));
		emit(jal_word(5'd7, 21'd12));
		emit(imm_op(3'd0, 5'd7, 5'd0, 12'd6));
		emit(imm_op(3'd0, 5'd1, 5'd0, 12'd7));
		emit(reg_op(7'h00, 3'd0, 5'd2, 5'd7, 5'd0));
		emit(branch_word(3'd0, 5'd5, 5'd5, 13'd8));
		emit(imm_op(3'd0, 5'd2, 5'd0, 12'd1));
		emit(jal_word(5'd0, 21'd0));
	endtask

	task automatic x0_program();
		clear_program();
		emit_prologue();
		emit(imm_op(3'd0, 5'd0, 5'd0, 12'd123));
		emit(reg_op(7'h00, 3'd0, 5'd0, 5'd1, 5'd2));
		emit(lui_word(5'd0, 20'h12345));
		emit(reg_op(7'h00, 3'd0, 5'd3, 5'd0, 5'd0));
		emit(imm_op(3'd0, 5'd4, 5'd0, 12'd9));
		emit(reg_op(7'h00, 3'd6, 5'd5, 5'd0, 5'd1));
		emit(jal_word(5'd0, 21'd8));
		emit(imm_op(3'd0, 5'd6, 5'd0, 12'd1));
		emit(reg_op(7'h00, 3'd4, 5'd6, 5'd0, 5'd0));
		emit(jal_word(5'd0, 21'd0));
	endtask

	// 40 random instructions on x0..x7, forward control flow only
	task automatic random_program();
		logic [3:0] kind;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		int         k;
		int         i;
		clear_program();
		for (i = 1; i < 8; i++) begin
			emit(imm_op(3'd0, 5'(i), 5'd0, 12'(take_bits(12))));
		end
		for (i = 0; i < 40; i++) begin
			kind = 4'(take_bits(4));
			rd = 5'(take_bits(3));
			rs1 = 5'(take_bits(3));
			rs2 = 5'(take_bits(3));
			k = int'(take_bits(2)) + 1;
			// never past the closing self jump
			if (i + k > 40) begin
				k = 40 - i;
			end
			case (kind)
				4'd1:    emit(imm_op(3'd7, rd, rs1, 12'(take_bits(12))));
				4'd2:    emit(imm_op(3'd6, rd, rs1, 12'(take_bits(12))));
				4'd3:    emit(imm_op(3'd4, rd, rs1, 12'(take_bits(12))));
				4'd4:    emit(imm_op(3'd1, rd, rs1, {6'd0, 6'(take_bits(6))}));
				4'd5:    emit(reg_op(7'h00, 3'd0, rd, rs1, rs2));
				4'd6:    emit(reg_op(7'h20, 3'd0, rd, rs1, rs2));
				4'd7:    emit(reg_op(7'h00, 3'd7, rd, rs1, rs2));
				4'd8:    emit(reg_op(7'h00, 3'd6, rd, rs1, rs2));
				4'd9:    emit(reg_op(7'h00, 3'd4, rd, rs1, rs2));
				4'd10:   emit(lui_word(rd, 20'(take_bits(20))));
				4'd11:   emit(branch_word(3'd0, rs1, rs2, 13'(4 * k)));
				4'd12:   emit(branch_word(3'd1, rs1, rs2, 13'(4 * k)));
				4'd13:   emit(jal_word(rd, 21'(4 * k)));
				default: emit(imm_op(3'd0, rd, rs1, 12'(take_bits(12))));
			endcase
		end
		emit(jal_word(5'd0, 21'd0));
	endtask

	// ******************************
	// reset, load, run
	// ******************************
	task automatic run_program(input string name);
		int a;
		int cycles;
		if (aborted) begin
			return;
		end
		prog_name = name;
		@(negedge clk);
		rst = 1'b1;
		start = 1'b0;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		seen = 0;
		exp_count = run_ref_model();
		for (a = 0; a < IMEM_DEPTH; a++) begin
			imem_we = 1'b1;
			imem_waddr = IMEM_ADDR_W'(a);
			imem_wdata = prog[a];
			@(negedge clk);
		end
		imem_we = 1'b0;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		// seen only moves on falling edges
		cycles = 0;
		while (seen < exp_count && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (seen < exp_count) begin
			$display("ERROR: program %s timed out after %0d of %0d retirements",
				name, seen, exp_count);
			timeouts++;
			aborted = 1'b1;
		end
	endtask

	task automatic mismatch(input string msg);
		$display("MISMATCH at time %0t: %s", $time, msg);
		mismatches++;
	endtask

	// ******************************
	// retire compare
	// ******************************
	// rd and data only matter when the instruction writes
	always @(negedge clk) begin
		if (retire_valid && seen < exp_count) begin
			if (retire_pkt.pc !== exp_pc[seen]) begin
				mismatch($sformatf("%s retire %0d pc %h, expected %h",
					prog_name, seen, retire_pkt.pc, exp_pc[seen]));
			end
			if (retire_pkt.wen !== exp_wen[seen]) begin
				mismatch($sformatf("%s retire %0d wen %b, expected %b",
					prog_name, seen, retire_pkt.wen, exp_wen[seen]));
			end
			if (exp_wen[seen] && retire_pkt.rd !== exp_rd[seen]) begin
				mismatch($sformatf("%s retire %0d rd %0d, expected %0d",
					prog_name, seen, retire_pkt.rd, exp_rd[seen]));
			end
			if (exp_wen[seen] && retire_pkt.data !== exp_data[seen]) begin
				mismatch($sformatf("%s retire %0d data %h, expected %h",
					prog_name, seen, retire_pkt.data, exp_data[seen]));
			end
			// counter lags retire_valid by one edge
			if (retire_count !== 32'(seen)) begin
				mismatch($sformatf("%s retire_count %0d, expected %0d",
					prog_name, retire_count, seen));
			end
			seen++;
		end
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		imem_we = 1'b0;
		imem_waddr = '0;
		imem_wdata = '0;
		lfsr = 32'h8689;
		prog_len = 0;
		exp_count = 0;
		seen = 0;
		mismatches = 0;
		timeouts = 0;
		aborted = 1'b0;
		alu_program();
		run_program("alu ops");
		raw_chain_program();
		run_program("raw chain");
		branch_program();
		run_program("branches");
		x0_program();
		run_program("x0 writes");
		random_program();
		run_program("random");
		$display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+bench
hw/rv_isa_pkg.sv
hw/core_pkg.sv
hw/regfile.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/execute_unit.sv
hw/writeback_unit.sv
hw/core_top.sv
bench/core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module core_tb -o core_tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/core_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
	exit 1
fi
exit 0
